/* compile.f */
hdl/inspect_pkg.sv
hdl/payload_if.sv
hdl/pattern_dfa.sv
hdl/depth_counter.sv
hdl/rule_context.sv
hdl/packet_sequencer.sv
hdl/content_inspect_top.sv
testbench/tb_content_inspect.sv

/* hdl/content_inspect_top.sv */
module content_inspect_top #(
   parameter int MAX_DEPTH = 64
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    sop,
   input  inspect_pkg::stream_id_t stream_id,
   input  inspect_pkg::byte_t      byte_in,
   input  logic                    byte_vld,
   input  logic                    eop,
   input  logic                    rule_enable,
   output inspect_pkg::count_t     match_count,
   output logic                    fired
);

   // Byte stream and context controls
   payload_if pl_bus ();

   // Depth limit back to the sequencer
   logic depth_reached;

   packet_sequencer u_seq (
      .clk           (clk),
      .rst_n         (rst_n),
      .sop           (sop),
      .stream_id     (stream_id),
      .byte_in       (byte_in),
      .byte_vld      (byte_vld),
      .eop           (eop),
      .enable        (rule_enable),
      .depth_reached (depth_reached),
      .pl            (pl_bus.src)
   );

   // Restarts at each packet load and counts forwarded bytes
   depth_counter #(
      .MAX_DEPTH (MAX_DEPTH)
   ) u_depth (
      .clk           (clk),
      .rst_n         (rst_n),
      .clear         (pl_bus.load_state),
      .count_en      (pl_bus.pl_vld),
      .depth_reached (depth_reached)
   );

   rule_context u_ctx (
      .clk    (clk),
      .rst_n  (rst_n),
      .pl     (pl_bus.ctx),
      .enable (rule_enable),
      .count  (match_count),
      .fired  (fired)
   );

endmodule

/* hdl/depth_counter.sv */
module depth_counter #(
   parameter int MAX_DEPTH = 64
) (
   input  logic clk,
   input  logic rst_n,
   input  logic clear,
   input  logic count_en,
   output logic depth_reached
);

   import inspect_pkg::*;

   localparam depth_t LIMIT = depth_t'(MAX_DEPTH);

   // Bytes forwarded in this packet
   depth_t depth_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         depth_q <= '0;
      else if (clear)
         depth_q <= '0;
      else if (count_en && (depth_q != LIMIT))
         depth_q <= depth_q + 1'b1;
   end

   // Also counts the byte on the bus this cycle
   // The sequencer samples the next byte before that one is counted
   assign depth_reached = (depth_q == LIMIT) ||
                          (count_en && (depth_q == LIMIT - 1'b1));

   // Sequencer must stop forwarding at the limit
   a_depth_max: assert property (@(posedge clk) disable iff (!rst_n)
      (depth_q == LIMIT) |-> !count_en);

endmodule

/* hdl/inspect_pkg.sv */
package inspect_pkg;

   // One payload character
   typedef logic [7:0] byte_t;

   // Stream number, 64 streams
   typedef logic [5:0] stream_id_t;

   // Number of tracked streams
   localparam int NUM_STREAMS = 64;

   // Matcher state
   // Counts pattern characters matched so far, 0 to 4
   typedef logic [2:0] dfa_state_t;

   // Per-rule match count, wraps on overflow
   typedef logic [15:0] count_t;

   // Inspected bytes in the current packet
   typedef logic [15:0] depth_t;

   // Length of the "USER " literal
   localparam int PATTERN_LEN = 5;

   // Packet sequencer states
   typedef enum logic [2:0]
   {
      // Waiting for sop
      SEQ_IDLE,
      // Context load pulse goes out
      SEQ_LOAD,
      // Restored state reaches the DFA
      SEQ_RESTORE,
      // Bytes forwarded until eop
      SEQ_PAYLOAD,
      // End of packet seen, state saved
      SEQ_CLOSE
   } seq_state_t;

endpackage

/* hdl/packet_sequencer.sv */
module packet_sequencer (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    sop,
   input  inspect_pkg::stream_id_t stream_id,
   input  inspect_pkg::byte_t      byte_in,
   input  logic                    byte_vld,
   input  logic                    eop,
   input  logic                    enable,
   input  logic                    depth_reached,
   payload_if.src                  pl
);

   import inspect_pkg::*;

   seq_state_t             state;

   // Streams that already have saved state
   logic [NUM_STREAMS-1:0] seen;

   logic                   start;
   logic                   take_byte;

   // sop only counts while idle
   assign start = (state == SEQ_IDLE) && sop;

   // Forward bytes inside a packet until the depth limit
   assign take_byte = (state == SEQ_PAYLOAD) && byte_vld && !depth_reached;

   // Control state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state         <= SEQ_IDLE;
         seen          <= '0;
         pl.load_state <= 1'b0;
         pl.pl_vld     <= 1'b0;
         pl.pl_eop     <= 1'b0;
      end
      else
      begin
         // Strobes are single-cycle by default
         pl.load_state <= 1'b0;
         pl.pl_vld     <= take_byte;
         pl.pl_eop     <= 1'b0;
         case (state)
            SEQ_IDLE:
            begin
               if (sop)
               begin
                  state         <= SEQ_LOAD;
                  pl.load_state <= 1'b1;
               end
            end
            SEQ_LOAD:
               state <= SEQ_RESTORE;
            SEQ_RESTORE:
               state <= SEQ_PAYLOAD;
            SEQ_PAYLOAD:
            begin
               if (eop)
               begin
                  state     <= SEQ_CLOSE;
                  pl.pl_eop <= 1'b1;
               end
            end
            SEQ_CLOSE:
            begin
               // Same cycle as pl_eop, so enable matches the state save
               if (enable)
                  seen[pl.stream_id] <= 1'b1;
               state <= SEQ_IDLE;
            end
            default:
               state <= SEQ_IDLE;
         endcase
      end
   end

   // Packet context and payload byte
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         pl.stream_id  <= stream_id;
         pl.new_stream <= !seen[stream_id];
      end
      if (take_byte)
         pl.pl_char <= byte_in;
   end

   // Overlapping packets are not supported upstream
   a_sop_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (state == SEQ_IDLE) || !sop);

endmodule

/* hdl/pattern_dfa.sv */
module pattern_dfa (
   input  logic                    clk,
   input  logic                    rst_n,
   input  inspect_pkg::byte_t      char_in,
   input  logic                    char_in_vld,
   input  inspect_pkg::dfa_state_t state_in,
   input  logic                    state_in_vld,
   output inspect_pkg::dfa_state_t state_out,
   output logic                    accept_out
);

   import inspect_pkg::*;

   // POP3 login command, first character in the top byte
   localparam logic [PATTERN_LEN*8-1:0] PATTERN = "USER ";

   dfa_state_t state_q;
   dfa_state_t state_nxt;
   logic       accept_nxt;

   // Expected character for a given matched-prefix length
   function automatic byte_t pat_char(input dfa_state_t idx);
      byte_t c;
      c = 8'h00;
      for (int i = 0; i < PATTERN_LEN; i++)
      begin
         if (dfa_state_t'(i) == idx)
            c = PATTERN[(PATTERN_LEN - 1 - i) * 8 +: 8];
      end
      return c;
   endfunction

   // Next state for one input byte
   // Only the first character repeats in the literal
   // So the KMP failure link is always to state 1 on 'U', else to 0
   always_comb
   begin
      state_nxt  = state_q;
      accept_nxt = 1'b0;
      if (char_in == pat_char(state_q))
      begin
         if (state_q == dfa_state_t'(PATTERN_LEN - 1))
         begin
            // Full literal seen, start over
            state_nxt  = '0;
            accept_nxt = 1'b1;
         end
         else
            state_nxt = state_q + 1'b1;
      end
      else if (char_in == pat_char('0))
         state_nxt = dfa_state_t'(1);
      else
         state_nxt = '0;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q    <= '0;
         accept_out <= 1'b0;
      end
      else
      begin
         accept_out <= 1'b0;
         // A restore wins over a byte in the same cycle
         if (state_in_vld)
            state_q <= state_in;
         else if (char_in_vld)
         begin
            state_q    <= state_nxt;
            accept_out <= accept_nxt;
         end
      end
   end

   assign state_out = state_q;

   // Restored states come from the context memory
   a_state_range: assert property (@(posedge clk) disable iff (!rst_n)
      state_q <= dfa_state_t'(PATTERN_LEN - 1));

endmodule

/* hdl/payload_if.sv */
interface payload_if;

   import inspect_pkg::*;

   // Payload byte and its strobe
   byte_t      pl_char;
   logic       pl_vld;

   // End of packet, one cycle
   logic       pl_eop;

   // Start of packet context load, one cycle
   logic       load_state;

   // Stream of the current packet, held until the next load
   stream_id_t stream_id;

   // Stream has no saved state yet
   // Only meaningful together with load_state
   logic       new_stream;

   // Sequencer side
   modport src (
      output pl_char, pl_vld, pl_eop, load_state, stream_id, new_stream
   );

   // Rule context side
   modport ctx (
      input  pl_char, pl_vld, pl_eop, load_state, stream_id, new_stream
   );

endinterface

/* hdl/rule_context.sv */
module rule_context (
   input  logic                 clk,
   input  logic                 rst_n,
   payload_if.ctx               pl,
   input  logic                 enable,
   output inspect_pkg::count_t  count,
   output logic                 fired
);

   import inspect_pkg::*;

   // Saved matcher state per stream
   dfa_state_t state_mem [NUM_STREAMS];

   // Restore path into the DFA
   dfa_state_t state_in;
   logic       state_in_vld;

   dfa_state_t state_out;
   logic       accept_out;

   // Packet matched at least once
   logic       match_flag;

   pattern_dfa u_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (pl.pl_char),
      .char_in_vld  (pl.pl_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

   // Restore one cycle after the load pulse
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= pl.load_state;
   end

   // New streams start from the empty prefix
   always_ff @(posedge clk)
   begin
      if (pl.load_state)
      begin
         if (pl.new_stream)
            state_in <= '0;
         else
            state_in <= state_mem[pl.stream_id];
      end
   end

   // Save state at end of packet for enabled rules only
   always_ff @(posedge clk)
   begin
      if (pl.pl_eop && enable)
         state_mem[pl.stream_id] <= state_out;
   end

   // Match flag and count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count      <= '0;
         match_flag <= 1'b0;
      end
      else
      begin
         if (pl.load_state)
            match_flag <= 1'b0;
         if (accept_out)
            match_flag <= 1'b1;
         if (pl.pl_eop)
         begin
            // At most one count per packet
            if (enable)
               count <= count + count_t'(match_flag);
            else
               match_flag <= 1'b0;
         end
      end
   end

   assign fired = match_flag;

   // Load and end of packet come from different sequencer states
   a_load_eop: assert property (@(posedge clk) disable iff (!rst_n)
      !(pl.load_state && pl.pl_eop));

   // Restore must land before any byte reaches the DFA
   a_load_gap: assert property (@(posedge clk) disable iff (!rst_n)
      pl.load_state |=> !pl.pl_vld);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the content inspection testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f compile.f \
   --top-module tb_content_inspect \
   -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/Vtb_content_inspect)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "test passed"; then
   echo "simulation ok"
   exit 0
else
   echo "simulation reported failure"
   exit 1
fi

/* testbench/tb_content_inspect.sv */
module tb_content_inspect;

   import inspect_pkg::*;

   localparam int MAX_DEPTH    = 64;
   localparam int CLK_PERIOD   = 8;

   // Sizes used to bound the run time
   localparam int DIRECTED_BYTES  = 200;
   localparam int RAND_PACKETS    = 40;
   localparam int RAND_MAX_LEN    = 24;
   localparam int WATCHDOG_CYCLES = (DIRECTED_BYTES + RAND_PACKETS * RAND_MAX_LEN) * 8 + 1000;

   logic       clk;
   logic       rst_n;
   logic       sop;
   stream_id_t stream_id;
   byte_t      byte_in;
   logic       byte_vld;
   logic       eop;
   logic       rule_enable;
   count_t     match_count;
   logic       fired;

   // Payload of the next packet
   byte_t      pkt [$];

   // Reference model state per stream
   int         model_state [NUM_STREAMS];
   bit         model_seen  [NUM_STREAMS];
   count_t     model_count;

   string      pattern_str = "USER ";
   logic [31:0] lcg_state  = 32'h5068;
   int         checks;
   int         errors;

   content_inspect_top #(
      .MAX_DEPTH (MAX_DEPTH)
   ) DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .sop         (sop),
      .stream_id   (stream_id),
      .byte_in     (byte_in),
      .byte_vld    (byte_vld),
      .eop         (eop),
      .rule_enable (rule_enable),
      .match_count (match_count),
      .fired       (fired)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Upper half of the LCG word is the better mixed part
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {16'h0, lcg_state[31:16]};
   endfunction

   // Longest pattern prefix that ends the matched text followed by c
   function automatic int kmp_next(input int s, input byte_t c);
      byte_t txt [PATTERN_LEN];
      int    len;
      int    best;
      bit    ok;
      for (int i = 0; i < s; i++)
         txt[i] = byte_t'(pattern_str[i]);
      txt[s] = c;
      len  = s + 1;
      best = 0;
      for (int k = 1; k <= len; k++)
      begin
         ok = 1'b1;
         for (int j = 0; j < k; j++)
         begin
            if (txt[len - k + j] != byte_t'(pattern_str[j]))
               ok = 1'b0;
         end
         if (ok)
            best = k;
      end
      return best;
   endfunction

   task automatic add_text(input string t);
      for (int i = 0; i < t.len(); i++)
         pkt.push_back(byte_t'(t[i]));
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_count(input string name, input count_t got, input count_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_fired(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   // Drives one packet from pkt with the minimum gaps
   task automatic send_packet(input stream_id_t stream, input logic en);
      sop         = 1'b1;
      stream_id   = stream;
      rule_enable = en;
      next_cycle();
      sop = 1'b0;
      repeat (2) next_cycle();
      // Context load has cleared the packet flag by now
      check_fired("fired", fired, 1'b0);
      foreach (pkt[i])
      begin
         byte_in  = pkt[i];
         byte_vld = 1'b1;
         next_cycle();
      end
      byte_vld = 1'b0;
      repeat (2) next_cycle();
      eop = 1'b1;
      next_cycle();
      eop = 1'b0;
      // Count is final here, and the next sop may follow
      repeat (2) next_cycle();
   endtask

   // Model update, packet on the DUT, then compare
   task automatic run_packet(input stream_id_t stream, input logic en);
      int s;
      int n;
      bit matched;
      s       = model_seen[stream] ? model_state[stream] : 0;
      n       = (pkt.size() < MAX_DEPTH) ? pkt.size() : MAX_DEPTH;
      matched = 1'b0;
      for (int i = 0; i < n; i++)
      begin
         s = kmp_next(s, pkt[i]);
         if (s == PATTERN_LEN)
         begin
            matched = 1'b1;
            s       = 0;
         end
      end
      // Only enabled packets count and leave state behind
      if (en)
      begin
         model_count        += count_t'(matched);
         model_state[stream] = s;
         model_seen[stream]  = 1'b1;
      end
      send_packet(stream, en);
      check_count("match_count", match_count, model_count);
      check_fired("fired", fired, en & matched);
      pkt.delete();
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, errors - errors_before);
   endtask

   task automatic test_single_match();
      int e0;
      e0 = errors;
      add_text("xxUSER yy");
      run_packet(6'd1, 1'b1);
      add_text("hello world");
      run_packet(6'd2, 1'b1);
      report_test("single_match", e0);
   endtask

   task automatic test_kmp_once();
      int e0;
      e0 = errors;
      add_text("UUSER ");
      run_packet(6'd3, 1'b1);
      // Second occurrence must not add again
      add_text("USER xUSER ");
      run_packet(6'd4, 1'b1);
      add_text("USUSER ");
      run_packet(6'd3, 1'b1);
      report_test("kmp_once", e0);
   endtask

   task automatic test_cross_packet();
      int e0;
      e0 = errors;
      add_text("US");
      run_packet(6'd5, 1'b1);
      add_text("ER ");
      run_packet(6'd5, 1'b1);
      // Interleaved stream sees its own fresh state
      add_text("US");
      run_packet(6'd6, 1'b1);
      add_text("ER ");
      run_packet(6'd7, 1'b1);
      add_text("ER ");
      run_packet(6'd6, 1'b1);
      add_text("zz");
      run_packet(6'd7, 1'b1);
      report_test("cross_packet", e0);
   endtask

   task automatic test_enable_low();
      int e0;
      e0 = errors;
      add_text("USER ");
      run_packet(6'd8, 1'b0);
      // Split over a disabled packet
      add_text("US");
      run_packet(6'd8, 1'b0);
      add_text("ER ");
      run_packet(6'd8, 1'b1);
      // Stream first seen while disabled stays new
      add_text("US");
      run_packet(6'd9, 1'b0);
      add_text("ER ");
      run_packet(6'd9, 1'b1);
      // Saved state survives a disabled packet
      add_text("xUS");
      run_packet(6'd10, 1'b1);
      add_text("qq");
      run_packet(6'd10, 1'b0);
      add_text("ER ");
      run_packet(6'd10, 1'b1);
      report_test("enable_low", e0);
   endtask

   task automatic test_depth_limit();
      int e0;
      e0 = errors;
      for (int i = 0; i < 70; i++)
         pkt.push_back("a");
      // Pattern on bytes 62 to 66, only "USE" is inspected
      for (int k = 0; k < PATTERN_LEN; k++)
         pkt[61 + k] = byte_t'(pattern_str[k]);
      run_packet(6'd11, 1'b1);
      add_text("R ");
      run_packet(6'd11, 1'b1);
      report_test("depth_limit", e0);
   endtask

   task automatic test_random_mix();
      int         e0;
      int         len;
      int         pos;
      stream_id_t s;
      logic       en;
      string      alphabet;
      e0       = errors;
      alphabet = "USER xq";
      for (int p = 0; p < RAND_PACKETS; p++)
      begin
         s   = stream_id_t'(32 + lcg_next() % 8);
         en  = (lcg_next() % 4) != 0;
         len = 1 + int'(lcg_next() % RAND_MAX_LEN);
         for (int i = 0; i < len; i++)
            pkt.push_back(byte_t'(alphabet[lcg_next() % 7]));
         // Plant a full pattern in about a third of the packets
         if ((lcg_next() % 3) == 0 && len >= PATTERN_LEN)
         begin
            pos = int'(lcg_next() % (len - PATTERN_LEN + 1));
            for (int k = 0; k < PATTERN_LEN; k++)
               pkt[pos + k] = byte_t'(pattern_str[k]);
         end
         run_packet(s, en);
      end
      report_test("random_mix", e0);
   endtask

   // Watchdog
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("test failed");
      $finish;
   end

   initial
   begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      sop         = 1'b0;
      stream_id   = '0;
      byte_in     = '0;
      byte_vld    = 1'b0;
      eop         = 1'b0;
      rule_enable = 1'b0;
      model_count = '0;
      checks      = 0;
      errors      = 0;
      foreach (model_state[i])
      begin
         model_state[i] = 0;
         model_seen[i]  = 1'b0;
      end
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      next_cycle();
      check_count("match_count", match_count, '0);
      check_fired("fired", fired, 1'b0);

      test_single_match();
      test_kmp_once();
      test_cross_packet();
      test_enable_low();
      test_depth_limit();
      test_random_mix();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
